/* common/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// cache geometry
`define FETCH_OFFSET_BITS 4
`define FETCH_INDEX_BITS 2
`define FETCH_LINES 4

// AR length field as beats minus one
`define FETCH_BURST_LEN 3

`define FETCH_RESET_PC 32'h0000_0000

// rom depth in words with addresses wrapping at 128 bytes
`define ROM_WORDS 32

// cycles from AR acceptance to the first beat
`define ROM_LATENCY 3

`endif

/* common/fetch_pkg.sv */
`include "fetch_consts.svh"

package fetch_pkg;

  // words per cache line
  localparam int LINE_WORDS = 2 ** (`FETCH_OFFSET_BITS - 2);

  // address fields above the line offset
  typedef logic [31-`FETCH_INDEX_BITS-`FETCH_OFFSET_BITS:0] tag_t;
  typedef logic [`FETCH_INDEX_BITS-1:0] index_t;

  // word 0 holds the lowest address
  typedef logic [LINE_WORDS-1:0][31:0] line_t;

  // read address request with a line aligned addr
  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
  } ar_req_t;

  // one read data beat
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
    logic        last;
  } r_beat_t;

  // instruction handed to the decoder
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_out_t;

endpackage

/* ifu/icache_store.sv */
`include "fetch_consts.svh"

module icache_store
  import fetch_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  index_t lookup_index,
  input  tag_t   lookup_tag,
  input  logic   fill_beat,
  input  logic   [31:0] fill_data,
  input  logic   flush_cache,
  output logic   hit,
  output line_t  line
);

  logic [`FETCH_LINES-1:0] valid;
  tag_t tags [`FETCH_LINES];
  line_t lines [`FETCH_LINES];

  // valid bits cleared all at once
  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else if (flush_cache) begin
      valid <= '0;
    end else if (fill_beat) begin
      valid[lookup_index] <= 1'b1;
    end
  end

  // each beat shifts the line down a word with the newest word on top
  always_ff @(posedge clock) begin
    if (fill_beat) begin
      tags[lookup_index] <= lookup_tag;
      lines[lookup_index] <= {fill_data, lines[lookup_index][LINE_WORDS-1:1]};
    end
  end

  assign hit = valid[lookup_index] && (tags[lookup_index] == lookup_tag);
  assign line = lines[lookup_index];

endmodule

/* ifu/fetch_ctrl.sv */
`include "fetch_consts.svh"

module fetch_ctrl
  import fetch_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  input  logic        npc_valid,
  input  logic [31:0] npc,
  input  logic        idu_ready,
  input  logic        block,
  input  logic        ar_ready,
  input  logic        r_valid,
  input  r_beat_t     r,
  input  logic        hit,
  input  line_t       line,
  output logic        fetch_valid,
  output fetch_out_t  fetch,
  output logic        fetch_busy,
  output logic        inst_addr_misaligned,
  output logic        ar_valid,
  output ar_req_t     ar,
  output logic        r_ready,
  output index_t      lookup_index,
  output tag_t        lookup_tag,
  output logic        fill_beat,
  output logic [31:0] fill_data
);

  localparam int TAG_LSB = `FETCH_OFFSET_BITS + `FETCH_INDEX_BITS;

  typedef enum logic {
    st_lookup,
    st_refill
  } state_t;

  state_t state;
  logic [31:0] pc;
  logic [31:0] refill_addr;
  logic [31:0] lookup_addr;
  logic pipeline_empty;
  logic [3:0] misalign_q;
  logic fetch_enable;
  logic miss_allowed;
  logic take_hit;
  logic issue_miss;
  logic r_fire;

  assign fetch_enable = (misalign_q == 4'b0) && (state == st_lookup) && !block && idu_ready;

  // only fetch from memory when the pc is known to be on the real path
  assign miss_allowed = pipeline_empty || (npc_valid && (npc == pc));

  assign take_hit = !redirect && fetch_enable && hit;
  assign issue_miss = !redirect && fetch_enable && !hit && miss_allowed;
  assign r_fire = r_valid && r_ready;

  // the refill keeps its own address even if the pc is redirected
  assign lookup_addr = (state == st_refill) ? refill_addr : pc;
  assign lookup_index = lookup_addr[TAG_LSB-1:`FETCH_OFFSET_BITS];
  assign lookup_tag = lookup_addr[31:TAG_LSB];

  assign fill_beat = r_fire;
  assign fill_data = r.data;

  assign ar = '{addr: refill_addr, len: 8'(`FETCH_BURST_LEN)};
  assign fetch_busy = (state == st_refill);
  assign inst_addr_misaligned = misalign_q[3];

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_lookup;
      pc <= `FETCH_RESET_PC;
      fetch_valid <= 1'b0;
      ar_valid <= 1'b0;
      r_ready <= 1'b0;
      pipeline_empty <= 1'b1;
      misalign_q <= 4'b0;
    end else begin
      // delay line fills with ones and only moves when not blocked
      if (!block) begin
        misalign_q[3:1] <= misalign_q[2:0];
      end

      if (redirect) begin
        pc <= redirect_pc;
        fetch_valid <= 1'b0;
        pipeline_empty <= 1'b1;
        if (redirect_pc[1:0] == 2'b00) begin
          misalign_q <= 4'b0;
        end else begin
          misalign_q <= 4'b0001;
        end
      end else if (fetch_enable) begin
        if (hit) begin
          fetch_valid <= 1'b1;
          pc <= pc + 32'd4;
          pipeline_empty <= 1'b0;
        end else begin
          fetch_valid <= 1'b0;
          if (miss_allowed) begin
            state <= st_refill;
            ar_valid <= 1'b1;
          end
        end
      end

      if (state == st_refill) begin
        if (ar_valid && ar_ready) begin
          ar_valid <= 1'b0;
          r_ready <= 1'b1;
        end
        if (r_fire && r.last) begin
          r_ready <= 1'b0;
          state <= st_lookup;
        end
      end
    end
  end

  // fetch payload and burst address
  always_ff @(posedge clock) begin
    if (redirect && (redirect_pc[1:0] != 2'b00)) begin
      fetch.pc <= redirect_pc;
    end else if (take_hit) begin
      fetch.pc <= pc;
      fetch.inst <= line[pc[`FETCH_OFFSET_BITS-1:2]];
    end
    if (issue_miss) begin
      refill_addr <= {pc[31:`FETCH_OFFSET_BITS], {`FETCH_OFFSET_BITS{1'b0}}};
    end
  end

endmodule

/* hdl/burst_rom.sv */
`include "fetch_consts.svh"

module burst_rom
  import fetch_pkg::*;
(
  input  logic    clock,
  input  logic    reset,
  input  logic    ar_valid,
  input  ar_req_t ar,
  input  logic    r_ready,
  output logic    ar_ready,
  output logic    r_valid,
  output r_beat_t r
);

  localparam int ADDR_BITS = $clog2(`ROM_WORDS);
  localparam int LAT_BITS = $clog2(`ROM_LATENCY + 1);

  typedef enum logic [1:0] {
    rom_idle,
    rom_wait,
    rom_burst
  } rom_state_t;

  rom_state_t state;
  logic [LAT_BITS-1:0] lat_cnt;
  logic [ADDR_BITS-1:0] word_addr;
  logic [7:0] beat_cnt;
  logic [7:0] beat_len;
  logic [31:0] mem [`ROM_WORDS];

  initial begin
    $readmemh("program.hex", mem);
  end

  assign ar_ready = (state == rom_idle);
  assign r_valid = (state == rom_burst);
  assign r = '{data: mem[word_addr], resp: 2'b00, last: (beat_cnt == beat_len)};

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= rom_idle;
      lat_cnt <= '0;
    end else begin
      case (state)
        rom_idle: begin
          if (ar_valid) begin
            state <= rom_wait;
            lat_cnt <= LAT_BITS'(1);
          end
        end
        rom_wait: begin
          if (lat_cnt == LAT_BITS'(`ROM_LATENCY - 1)) begin
            state <= rom_burst;
          end else begin
            lat_cnt <= lat_cnt + 1'b1;
          end
        end
        rom_burst: begin
          if (r_ready && r.last) begin
            state <= rom_idle;
          end
        end
        default: state <= rom_idle;
      endcase
    end
  end

  // word address wraps at the rom size
  always_ff @(posedge clock) begin
    if (ar_valid && ar_ready) begin
      word_addr <= ar.addr[ADDR_BITS+1:2];
      beat_len <= ar.len;
      beat_cnt <= 8'd0;
    end else if (r_valid && r_ready) begin
      word_addr <= word_addr + 1'b1;
      beat_cnt <= beat_cnt + 8'd1;
    end
  end

endmodule

/* hdl/fetch_top.sv */
module fetch_top
  import fetch_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        redirect,
  input  logic [31:0] redirect_pc,
  input  logic        npc_valid,
  input  logic [31:0] npc,
  input  logic        idu_ready,
  input  logic        block,
  input  logic        flush_cache,
  output logic        fetch_valid,
  output fetch_out_t  fetch,
  output logic        fetch_busy,
  output logic        inst_addr_misaligned
);

  logic ar_valid;
  logic ar_ready;
  ar_req_t ar;
  logic r_valid;
  logic r_ready;
  r_beat_t r;
  index_t lookup_index;
  tag_t lookup_tag;
  logic fill_beat;
  logic [31:0] fill_data;
  logic hit;
  line_t line;

  fetch_ctrl i_fetch_ctrl (
    .clock                (clock),
    .reset                (reset),
    .redirect             (redirect),
    .redirect_pc          (redirect_pc),
    .npc_valid            (npc_valid),
    .npc                  (npc),
    .idu_ready            (idu_ready),
    .block                (block),
    .ar_ready             (ar_ready),
    .r_valid              (r_valid),
    .r                    (r),
    .hit                  (hit),
    .line                 (line),
    .fetch_valid          (fetch_valid),
    .fetch                (fetch),
    .fetch_busy           (fetch_busy),
    .inst_addr_misaligned (inst_addr_misaligned),
    .ar_valid             (ar_valid),
    .ar                   (ar),
    .r_ready              (r_ready),
    .lookup_index         (lookup_index),
    .lookup_tag           (lookup_tag),
    .fill_beat            (fill_beat),
    .fill_data            (fill_data)
  );

  icache_store i_icache_store (
    .clock        (clock),
    .reset        (reset),
    .lookup_index (lookup_index),
    .lookup_tag   (lookup_tag),
    .fill_beat    (fill_beat),
    .fill_data    (fill_data),
    .flush_cache  (flush_cache),
    .hit          (hit),
    .line         (line)
  );

  burst_rom i_burst_rom (
    .clock    (clock),
    .reset    (reset),
    .ar_valid (ar_valid),
    .ar       (ar),
    .r_ready  (r_ready),
    .ar_ready (ar_ready),
    .r_valid  (r_valid),
    .r        (r)
  );

endmodule

/* dv/fetch_properties.sv */
module fetch_properties
  import fetch_pkg::*;
(
  input logic    clock,
  input logic    reset,
  input logic    ar_valid,
  input logic    ar_ready,
  input ar_req_t ar,
  input logic    r_valid,
  input logic    r_ready,
  input logic    fetch_valid,
  input logic    inst_addr_misaligned
);

  // one burst at a time
  a_no_ar_during_r: assert property (@(posedge clock) disable iff (reset)
    !(ar_valid && ar_ready && r_ready))
    else $error("AR transfer while the R channel is still receiving");

  // refills are line aligned
  a_ar_aligned: assert property (@(posedge clock) disable iff (reset)
    ar_valid |-> (ar.addr[3:0] == 4'h0))
    else $error("AR address is not line aligned");

  a_no_fetch_when_misaligned: assert property (@(posedge clock) disable iff (reset)
    !(fetch_valid && inst_addr_misaligned))
    else $error("fetch_valid high while the misaligned flag is set");

  // a beat stays offered until taken
  a_r_valid_held: assert property (@(posedge clock) disable iff (reset)
    (r_valid && !r_ready) |=> r_valid)
    else $error("r_valid dropped before the beat transferred");

endmodule

/* dv/fetch_tb.sv */
`include "fetch_consts.svh"

module fetch_tb
  import fetch_pkg::*;
();

  localparam int NUM_ROWS = 14;
  localparam int WAIT_LIMIT = 200;

  typedef struct packed {
    logic        has_redirect;
    logic [31:0] target;
    int          count;
    logic        random_stall;
    logic        flush;
    logic        expect_refill;
  } stim_t;

  logic clock;
  logic reset;
  logic redirect;
  logic [31:0] redirect_pc;
  logic npc_valid;
  logic [31:0] npc;
  logic idu_ready;
  logic block;
  logic flush_cache;
  logic fetch_valid;
  fetch_out_t fetch;
  logic fetch_busy;
  logic inst_addr_misaligned;

  logic [31:0] model_mem [`ROM_WORDS];
  stim_t rows [NUM_ROWS];
  string row_names [NUM_ROWS];
  logic [31:0] lfsr_state;
  logic cur_ready;
  logic cur_block;
  logic applied_ready;
  logic applied_block;
  logic saw_busy;
  logic timed_out;
  int checks;
  int errors;
  int tests_run;

  fetch_top i_dut (
    .clock                (clock),
    .reset                (reset),
    .redirect             (redirect),
    .redirect_pc          (redirect_pc),
    .npc_valid            (npc_valid),
    .npc                  (npc),
    .idu_ready            (idu_ready),
    .block                (block),
    .flush_cache          (flush_cache),
    .fetch_valid          (fetch_valid),
    .fetch                (fetch),
    .fetch_busy           (fetch_busy),
    .inst_addr_misaligned (inst_addr_misaligned)
  );

  bind fetch_ctrl fetch_properties i_props (
    .clock                (clock),
    .reset                (reset),
    .ar_valid             (ar_valid),
    .ar_ready             (ar_ready),
    .ar                   (ar),
    .r_valid              (r_valid),
    .r_ready              (r_ready),
    .fetch_valid          (fetch_valid),
    .inst_addr_misaligned (inst_addr_misaligned)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #2 clock = ~clock;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr_state = lfsr_next(lfsr_state);
    b = lfsr_state[0];
  endtask

  task automatic check_fetch(input string name, input fetch_out_t got, input fetch_out_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s pc=%h inst=%h, expected pc=%h inst=%h",
               name, got.pc, got.inst, exp.pc, exp.inst);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic fill_table();
    // redirect, target, count, random stall, flush, refill expected
    rows[0] = '{1'b0, 32'h0000_0000, 4, 1'b0, 1'b0, 1'b1};
    rows[1] = '{1'b1, 32'h0000_0010, 4, 1'b0, 1'b0, 1'b1};
    rows[2] = '{1'b1, 32'h0000_0020, 4, 1'b0, 1'b0, 1'b1};
    rows[3] = '{1'b1, 32'h0000_0030, 4, 1'b0, 1'b0, 1'b1};
    rows[4] = '{1'b1, 32'h0000_0014, 3, 1'b0, 1'b0, 1'b0};
    rows[5] = '{1'b1, 32'h0000_0048, 2, 1'b0, 1'b0, 1'b1};
    rows[6] = '{1'b1, 32'h0000_0004, 3, 1'b0, 1'b0, 1'b1};
    rows[7] = '{1'b1, 32'h0000_0030, 4, 1'b1, 1'b0, 1'b0};
    rows[8] = '{1'b1, 32'h0000_0050, 4, 1'b1, 1'b0, 1'b1};
    rows[9] = '{1'b1, 32'h0000_0022, 0, 1'b1, 1'b0, 1'b0};
    rows[10] = '{1'b1, 32'h0000_0024, 3, 1'b0, 1'b0, 1'b0};
    rows[11] = '{1'b1, 32'h0000_0024, 3, 1'b0, 1'b1, 1'b1};
    rows[12] = '{1'b1, 32'h0000_0074, 3, 1'b1, 1'b0, 1'b1};
    rows[13] = '{1'b1, 32'h0000_00c8, 2, 1'b0, 1'b0, 1'b1};
    row_names = '{"reset fetch line 0", "sequential line 1", "sequential line 2",
                  "sequential line 3", "hit after refill", "conflict refill",
                  "refetch evicted line", "stalled hits", "stalled refill",
                  "misaligned redirect", "aligned resume", "flush and refetch",
                  "stalled conflict", "address wrap"};
  endtask

  // new stall levels at the rising edge and outputs read at the falling edge
  task automatic step_cycle(input logic random_stall);
    logic ready_bit;
    logic block_a;
    logic block_b;
    @(posedge clock);
    applied_ready = cur_ready;
    applied_block = cur_block;
    redirect <= 1'b0;
    flush_cache <= 1'b0;
    if (random_stall) begin
      take_bit(ready_bit);
      take_bit(block_a);
      take_bit(block_b);
      cur_ready = ready_bit;
      cur_block = block_a & block_b;
    end else begin
      cur_ready = 1'b1;
      cur_block = 1'b0;
    end
    idu_ready <= cur_ready;
    block <= cur_block;
    @(negedge clock);
    if (fetch_busy) begin
      saw_busy = 1'b1;
    end
  endtask

  task automatic send_flush();
    @(posedge clock);
    flush_cache <= 1'b1;
    idu_ready <= 1'b0;
    block <= 1'b0;
    cur_ready = 1'b0;
    cur_block = 1'b0;
  endtask

  task automatic send_redirect(input logic [31:0] target);
    @(posedge clock);
    redirect <= 1'b1;
    redirect_pc <= target;
    flush_cache <= 1'b0;
    idu_ready <= 1'b0;
    block <= 1'b0;
    cur_ready = 1'b0;
    cur_block = 1'b0;
  endtask

  // waits for each fetch_valid and checks pc and word against the model
  task automatic collect(input stim_t row);
    logic [31:0] exp_pc;
    fetch_out_t exp;
    fetch_out_t held;
    logic held_valid;
    int got;
    int cycles;
    exp_pc = row.has_redirect ? row.target : `FETCH_RESET_PC;
    got = 0;
    cycles = 0;
    while (got < row.count && cycles < WAIT_LIMIT) begin
      held = fetch;
      held_valid = fetch_valid;
      step_cycle(row.random_stall);
      cycles++;
      if (applied_ready && !applied_block) begin
        if (fetch_valid) begin
          exp.pc = exp_pc;
          // byte address modulo 128
          exp.inst = model_mem[exp_pc[6:2]];
          check_fetch("fetch", fetch, exp);
          exp_pc = exp_pc + 32'd4;
          got++;
        end
      end else begin
        check_flag("fetch_valid while stalled", fetch_valid, held_valid);
        if (held_valid) begin
          check_fetch("fetch while stalled", fetch, held);
        end
      end
    end
    if (got < row.count) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: only %0d of %0d instructions arrived", got, row.count);
    end
  endtask

  // flag rises after three unblocked cycles and then must stay up
  task automatic watch_misaligned(input stim_t row);
    int advances;
    int cycles;
    advances = 0;
    cycles = 0;
    while (advances < 6 && cycles < WAIT_LIMIT) begin
      step_cycle(row.random_stall);
      cycles++;
      if (!applied_block) begin
        advances++;
      end
      check_flag("fetch_valid", fetch_valid, 1'b0);
      check_flag("inst_addr_misaligned", inst_addr_misaligned, advances >= 3);
    end
    if (advances < 6) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: misaligned flag delay never completed");
    end
    check_word("fetch.pc", fetch.pc, row.target);
  endtask

  task automatic run_row(input int idx);
    stim_t row;
    int errors_before;
    row = rows[idx];
    errors_before = errors;
    saw_busy = 1'b0;
    if (row.flush) begin
      send_flush();
    end
    if (row.has_redirect) begin
      send_redirect(row.target);
      step_cycle(row.random_stall);
      check_flag("fetch_valid", fetch_valid, 1'b0);
      check_flag("inst_addr_misaligned", inst_addr_misaligned, 1'b0);
    end
    if (row.target[1:0] != 2'b00) begin
      watch_misaligned(row);
    end else begin
      collect(row);
    end
    if (!timed_out) begin
      check_flag("fetch_busy seen", saw_busy, row.expect_refill);
    end
    tests_run++;
    $display("test %0d %s: %s", idx, row_names[idx],
             (errors == errors_before) ? "ok" : "errors");
  endtask

  initial begin
    reset = 1'b1;
    redirect = 1'b0;
    redirect_pc = 32'h0;
    npc_valid = 1'b0;
    npc = 32'h0;
    idu_ready = 1'b0;
    block = 1'b0;
    flush_cache = 1'b0;
    lfsr_state = 32'h8a9e;
    cur_ready = 1'b0;
    cur_block = 1'b0;
    applied_ready = 1'b0;
    applied_block = 1'b0;
    saw_busy = 1'b0;
    timed_out = 1'b0;
    checks = 0;
    errors = 0;
    tests_run = 0;
    $readmemh("program.hex", model_mem);
    fill_table();
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
      run_row(i);
    end
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* program.hex */
// one 32-bit instruction word per line, word 0 at byte address 0
// 32 words fill the 128-byte rom, eight 16-byte cache lines
00000013
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793
01000813
01100893
01200913
01300993
01400a13
01500a93
01600b13
01700b93
01800c13
01900c93
01a00d13
01b00d93
01c00e13
01d00e93
01e00f13
01f00f93

/* flist.f */
+incdir+common
common/fetch_pkg.sv
ifu/icache_store.sv
ifu/fetch_ctrl.sv
hdl/burst_rom.sv
hdl/fetch_top.sv
dv/fetch_properties.sv
dv/fetch_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module fetch_tb -f flist.f -o fetch_sim

out=$(./obj_dir/fetch_sim)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1
